/* logic/cart_macros.svh */
// Cartridge loader constants
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

// Download bus widths
`define CART_ADDR_W 25
`define CART_DATA_W 16

// Product code, eight ASCII characters
`define CART_ID_W 64

//////////////////////////////
// Header byte offsets
//////////////////////////////
`define HDR_ID_FIRST 25'h182 // First word of the product code
`define HDR_ID_LAST 25'h18C // Code complete, lookup fires here
`define HDR_REGION_A 25'h1F0
`define HDR_REGION_B 25'h1F2
`define HDR_DONE 25'h200 // End of the header

//////////////////////////////
// Light gun
//////////////////////////////
`define GUN_DELAY_W 8
`define GUN_DELAY_DEFAULT 8'd44

`endif

/* logic/cart_pkg.sv */
// Cartridge loader types
package cart_pkg;

	// Console region, matches the menu encoding
	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_e;

	// Region priority when the header lists several
	typedef enum logic [1:0] {
		US_EU_JP = 2'd0,
		EU_US_JP = 2'd1,
		US_JP_EU = 2'd2,
		JP_US_EU = 2'd3
	} region_prio_e;

	// Source of the automatic region choice
	typedef enum logic [1:0] {
		FILE_EXT = 2'd0,
		HEADER   = 2'd1,
		DISABLED = 2'd2
	} auto_region_e;

	// Per-cartridge compatibility flags
	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;  // Fake RAM check
		logic fifo;
		logic pier;
		logic svp;    // Virtua Racing DSP
		logic fmbusy;
		logic schan;
	} quirk_t;

endpackage

/* logic/cart_dl_if.sv */
// Download write bus
`timescale 1ns/1ps
`include "cart_macros.svh"

interface cart_dl_if;
	logic                    download; // Level, high for the whole file
	logic                    wr;       // One-cycle write strobe
	logic [`CART_ADDR_W-1:0] addr;     // Byte address of the word
	logic [`CART_DATA_W-1:0] data;

	modport src (
		output download,
		output wr,
		output addr,
		output data
	);

	modport snk (
		input download,
		input wr,
		input addr,
		input data
	);
endinterface

/* logic/rom_write_tracker.sv */
// ROM write handshake
`timescale 1ns/1ps
`include "cart_macros.svh"

module rom_write_tracker (
	input  logic                    clk_sys,
	input  logic                    RESET,
	cart_dl_if.snk                  dl,
	input  logic                    rom_ack,
	output logic                    rom_wr,
	output logic                    ioctl_wait,
	output logic [`CART_ADDR_W-1:0] rom_size
);

	logic                    download_q;
	logic [`CART_ADDR_W-1:0] last_addr;
	logic                    wr_en;
	logic                    dl_fall;

	assign wr_en   = dl.download & dl.wr;
	assign dl_fall = download_q & ~dl.download;

	// Toggle request, wait until storage echoes it back
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			download_q <= 1'b0;
			rom_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			download_q <= dl.download;
			if (wr_en) begin
				rom_wr     <= ~rom_wr;
				ioctl_wait <= 1'b1;
			end else if (ioctl_wait && (rom_ack == rom_wr)) begin
				ioctl_wait <= 1'b0; // Word stored
			end
		end
	end

	// Image size is the final word address
	always_ff @(posedge clk_sys) begin
		if (wr_en)
			last_addr <= dl.addr;
		if (dl_fall)
			rom_size <= last_addr;
	end

endmodule

/* logic/cart_header_scan.sv */
// Cartridge header scanner
`timescale 1ns/1ps
`include "cart_macros.svh"

module cart_header_scan (
	input  logic                  clk_sys,
	input  logic                  RESET,
	cart_dl_if.snk                dl,
	output logic [`CART_ID_W-1:0] cart_id,
	output logic                  id_done,
	output logic                  hdr_j,
	output logic                  hdr_u,
	output logic                  hdr_e,
	output logic                  hdr_ready
);

	logic       download_q;
	logic       wr_en;
	logic [2:0] lo_flags;
	logic [2:0] hi_flags;

	// Region letter to {j, u, e}
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		logic [2:0] f;
		f = 3'b000;
		if (c == "J")
			f = 3'b100;
		else if (c == "U")
			f = 3'b010;
		else if (c >= "0" && c <= "Z")
			f = 3'b001; // Anything else counts as Europe
		return f;
	endfunction

	assign wr_en    = dl.download & dl.wr;
	assign lo_flags = letter_flags(dl.data[7:0]);
	assign hi_flags = letter_flags(dl.data[15:8]);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			download_q <= 1'b0;
			id_done    <= 1'b0;
			hdr_ready  <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
		end else begin
			download_q <= dl.download;
			id_done    <= wr_en && (dl.addr == `HDR_ID_LAST);
			if (~download_q & dl.download)
				{hdr_j, hdr_u, hdr_e} <= 3'b000; // New file
			else if (wr_en && dl.addr == `HDR_REGION_A)
				{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | lo_flags | hi_flags;
			else if (wr_en && dl.addr == `HDR_REGION_B)
				{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | lo_flags;
			if (download_q & ~dl.download)
				hdr_ready <= 1'b0;
			else if (wr_en && dl.addr == `HDR_DONE)
				hdr_ready <= 1'b1;
		end
	end

	// Product code, bytes swapped within each word
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			case (dl.addr)
				`HDR_ID_FIRST:          cart_id[63:56] <= dl.data[15:8];
				`HDR_ID_FIRST + 25'd2:  cart_id[55:40] <= {dl.data[7:0], dl.data[15:8]};
				`HDR_ID_FIRST + 25'd4:  cart_id[39:24] <= {dl.data[7:0], dl.data[15:8]};
				`HDR_ID_FIRST + 25'd6:  cart_id[23:8]  <= {dl.data[7:0], dl.data[15:8]};
				`HDR_ID_FIRST + 25'd8:  cart_id[7:0]   <= dl.data[7:0];
				default: ;
			endcase
		end
	end

endmodule

/* logic/quirk_table.sv */
// Product code quirk lookup
`timescale 1ns/1ps
`include "cart_macros.svh"

module quirk_table import cart_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    download,
	input  logic [`CART_ID_W-1:0]   cart_id,
	input  logic                    id_done,
	output quirk_t                  quirks,
	output logic                    gun_type,
	output logic [`GUN_DELAY_W-1:0] gun_sensor_delay
);

	logic download_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			download_q       <= 1'b0;
			quirks           <= '0;
			gun_type         <= 1'b0;
			gun_sensor_delay <= `GUN_DELAY_DEFAULT;
		end else begin
			download_q <= download;
			if (~download_q & download)
				quirks <= '0; // Drop the previous cartridge
			if (id_done) begin
				//////////////////////////////
				// Compatibility flags
				//////////////////////////////
				case (cart_id)
					"T-081276", "T-81406 ", "T-081586", "T-81576 ",
					"T-81476 ":
						quirks.sram <= 1'b1;
					"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ",
					"G-5538  ", "00004076", "T-12046 ", "T-12053 ",
					"G-4524  ":
						quirks.eeprom <= 1'b1;
					"T-113016": quirks.noram <= 1'b1;
					"T-89016 ": quirks.fifo  <= 1'b1;
					"T-574023", "T-574013":
						quirks.pier <= 1'b1;
					"MK-1229 ", "G-7001  ":
						quirks.svp <= 1'b1;
					"T-35036 ", "T-25073 ", "MK-1137-":
						quirks.fmbusy <= 1'b1; // Hellfire, all regions
					"T-68???-": quirks.schan <= 1'b1;
					default: ;
				endcase

				//////////////////////////////
				// Light gun type and timing
				//////////////////////////////
				case (cart_id)
					"T-95096-": begin
						gun_type         <= 1'b1; // Justifier
						gun_sensor_delay <= 8'd52;
					end
					"T-95136-": begin
						gun_type         <= 1'b1;
						gun_sensor_delay <= 8'd30;
					end
					"MK-1533 ": begin
						gun_type         <= 1'b0;
						gun_sensor_delay <= 8'd100;
					end
					"MK-1658 ": begin
						gun_type         <= 1'b0;
						gun_sensor_delay <= 8'd120;
					end
					"T-081156": begin
						gun_type         <= 1'b0;
						gun_sensor_delay <= 8'd126;
					end
					default: begin
						gun_type         <= 1'b0; // Menacer
						gun_sensor_delay <= `GUN_DELAY_DEFAULT;
					end
				endcase
			end
		end
	end

endmodule

/* logic/region_select.sv */
// Automatic region selection
`timescale 1ns/1ps

module region_select import cart_pkg::*; (
	input  logic         clk_sys,
	input  logic         RESET,
	input  logic         hdr_j,
	input  logic         hdr_u,
	input  logic         hdr_e,
	input  logic         hdr_ready,
	input  auto_region_e auto_mode,
	input  region_prio_e prio,
	input  logic [7:0]   file_index,
	output region_e      region_req,
	output logic         region_set
);

	logic [1:0] ready_q;  // Two-stage delay of hdr_ready
	logic [2:0] hdr_vec;  // Indexed by region_e
	region_e    first;
	region_e    second;
	region_e    third;
	region_e    chosen;

	assign hdr_vec = {hdr_e, hdr_u, hdr_j};

	// Search order for each priority setting
	always_comb begin
		case (prio)
			US_EU_JP: {first, second, third} = {US, EU, JP};
			EU_US_JP: {first, second, third} = {EU, US, JP};
			US_JP_EU: {first, second, third} = {US, JP, EU};
			default:  {first, second, third} = {JP, US, EU};
		endcase
		if (hdr_vec[first])
			chosen = first;
		else if (hdr_vec[second])
			chosen = second;
		else if (hdr_vec[third])
			chosen = third;
		else
			chosen = first; // No letters, take the preferred region
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 2'b00;
			region_set <= 1'b0;
			region_req <= JP;
		end else begin
			ready_q <= {ready_q[0], hdr_ready};
			if (ready_q == 2'b01) begin
				if (auto_mode == HEADER) begin
					region_set <= 1'b1;
					region_req <= chosen;
				end else if (auto_mode == FILE_EXT) begin
					region_set <= |file_index;
					region_req <= region_e'(file_index[7:6]);
				end
			end
			if (ready_q == 2'b10)
				region_set <= 1'b0; // Header gone
		end
	end

endmodule

/* logic/cart_loader.sv */
// Cartridge loader top
`timescale 1ns/1ps
`include "cart_macros.svh"

module cart_loader import cart_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    download,
	input  logic                    wr,
	input  logic [`CART_ADDR_W-1:0] addr,
	input  logic [`CART_DATA_W-1:0] data,
	input  logic [7:0]              file_index,
	input  auto_region_e            auto_mode,
	input  region_prio_e            prio,
	input  logic                    rom_ack,
	output logic                    rom_wr,
	output logic                    ioctl_wait,
	output logic [`CART_ADDR_W-1:0] rom_size,
	output quirk_t                  quirks,
	output logic                    gun_type,
	output logic [`GUN_DELAY_W-1:0] gun_sensor_delay,
	output region_e                 region_req,
	output logic                    region_set
);

	logic [`CART_ID_W-1:0] cart_id;
	logic                  id_done;
	logic                  hdr_j;
	logic                  hdr_u;
	logic                  hdr_e;
	logic                  hdr_ready;

	// Download bus from the host side
	cart_dl_if dl ();

	assign dl.download = download;
	assign dl.wr       = wr;
	assign dl.addr     = addr;
	assign dl.data     = data;

	rom_write_tracker i_rom_write_tracker (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl         (dl),
		.rom_ack    (rom_ack),
		.rom_wr     (rom_wr),
		.ioctl_wait (ioctl_wait),
		.rom_size   (rom_size)
	);

	cart_header_scan i_cart_header_scan (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl        (dl),
		.cart_id   (cart_id),
		.id_done   (id_done),
		.hdr_j     (hdr_j),
		.hdr_u     (hdr_u),
		.hdr_e     (hdr_e),
		.hdr_ready (hdr_ready)
	);

	quirk_table i_quirk_table (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.download         (download),
		.cart_id          (cart_id),
		.id_done          (id_done),
		.quirks           (quirks),
		.gun_type         (gun_type),
		.gun_sensor_delay (gun_sensor_delay)
	);

	region_select i_region_select (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.hdr_j      (hdr_j),
		.hdr_u      (hdr_u),
		.hdr_e      (hdr_e),
		.hdr_ready  (hdr_ready),
		.auto_mode  (auto_mode),
		.prio       (prio),
		.file_index (file_index),
		.region_req (region_req),
		.region_set (region_set)
	);

endmodule

/* bench/cart_loader_tb.sv */
// Cartridge loader testbench
`timescale 1ns/1ps
`include "cart_macros.svh"

module cart_loader_tb import cart_pkg::*; ();

	localparam int MAX_TESTS = 16;

	logic                    clk_sys = 1'b0;
	logic                    RESET;
	logic                    download;
	logic                    wr;
	logic [`CART_ADDR_W-1:0] addr;
	logic [`CART_DATA_W-1:0] data;
	logic [7:0]              file_index;
	auto_region_e            auto_mode;
	region_prio_e            prio;
	logic                    rom_ack;
	logic                    rom_wr;
	logic                    ioctl_wait;
	logic [`CART_ADDR_W-1:0] rom_size;
	quirk_t                  quirks;
	logic                    gun_type;
	logic [`GUN_DELAY_W-1:0] gun_sensor_delay;
	region_e                 region_req;
	logic                    region_set;

	//////////////////////////////
	// Test table
	//////////////////////////////
	string                   names [MAX_TESTS];
	logic [`CART_ID_W-1:0]   codes [MAX_TESTS];
	logic [15:0]             reg_a [MAX_TESTS];
	logic [15:0]             reg_b [MAX_TESTS];
	auto_region_e            modes [MAX_TESTS];
	region_prio_e            prios [MAX_TESTS];
	logic [7:0]              indices [MAX_TESTS];
	quirk_t                  exp_quirks [MAX_TESTS];
	logic                    exp_gun [MAX_TESTS];
	logic [`GUN_DELAY_W-1:0] exp_delay [MAX_TESTS];
	region_e                 exp_region [MAX_TESTS];
	logic                    exp_set [MAX_TESTS];
	logic [`CART_ADDR_W-1:0] end_addrs [MAX_TESTS];

	int          num_tests = 0;
	int          errors = 0;
	int          test_errors = 0;
	int          failed_tests = 0;
	int          flips = 0;         // rom_wr toggles in the current test
	logic        wr_seen = 1'b0;
	logic [31:0] rng_state = 32'h6c61_0ac0;
	int          limit = 100;

	cart_loader i_cart_loader (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.download         (download),
		.wr               (wr),
		.addr             (addr),
		.data             (data),
		.file_index       (file_index),
		.auto_mode        (auto_mode),
		.prio             (prio),
		.rom_ack          (rom_ack),
		.rom_wr           (rom_wr),
		.ioctl_wait       (ioctl_wait),
		.rom_size         (rom_size),
		.quirks           (quirks),
		.gun_type         (gun_type),
		.gun_sensor_delay (gun_sensor_delay),
		.region_req       (region_req),
		.region_set       (region_set)
	);

	always #50 clk_sys = ~clk_sys; // 100 ns period

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y ^= y << 13;
		y ^= y >> 17;
		y ^= y << 5;
		return y;
	endfunction

	// Storage model echoes rom_wr after 1 to 4 cycles
	initial begin
		int delay;
		rom_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!RESET && rom_wr != rom_ack) begin
				rng_state = xorshift(rng_state);
				delay = int'(rng_state[1:0]) + 1;
				repeat (delay) @(negedge clk_sys);
				rom_ack = rom_wr;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (!RESET && rom_wr != wr_seen)
			flips++;
		wr_seen = rom_wr;
	end

	task automatic add_test(input string name, input logic [63:0] code, input logic [15:0] wa,
		input logic [15:0] wb, input auto_region_e mode, input region_prio_e pr,
		input logic [7:0] index, input quirk_t q, input logic gun, input logic [7:0] dly,
		input region_e reg_exp, input logic set_exp, input logic [24:0] end_addr);
		names[num_tests]      = name;
		codes[num_tests]      = code;
		reg_a[num_tests]      = wa;
		reg_b[num_tests]      = wb;
		modes[num_tests]      = mode;
		prios[num_tests]      = pr;
		indices[num_tests]    = index;
		exp_quirks[num_tests] = q;
		exp_gun[num_tests]    = gun;
		exp_delay[num_tests]  = dly;
		exp_region[num_tests] = reg_exp;
		exp_set[num_tests]    = set_exp;
		end_addrs[num_tests]  = end_addr;
		num_tests++;
	endtask

	task automatic compare(input string test, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp == act) else begin
			$display("CHECK FAILED %s %s expected %0h actual %0h", test, what, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	// Product code sits one byte after the first code word address
	function automatic logic [7:0] header_byte(input int t, input logic [24:0] b);
		int k;
		k = int'(b) - int'(`HDR_ID_FIRST) - 1;
		if (k >= 0 && k < 8)
			return codes[t][63 - 8 * k -: 8];
		return 8'h00;
	endfunction

	function automatic logic [15:0] word_for(input int t, input logic [24:0] a);
		if (a == `HDR_REGION_A)
			return reg_a[t];
		if (a == `HDR_REGION_B)
			return reg_b[t];
		return {header_byte(t, a + 25'd1), header_byte(t, a)}; // Byte-swapped word
	endfunction

	task automatic write_word(input int t, input logic [24:0] a, input logic [15:0] d);
		wr   = 1'b1;
		addr = a;
		data = d;
		@(negedge clk_sys);
		wr = 1'b0;
		compare(names[t], "ioctl_wait after write", 32'd1, 32'(ioctl_wait));
		while (ioctl_wait)
			@(negedge clk_sys); // Back-pressure from storage
	endtask

	task automatic run_test(input int t);
		logic [24:0] a;
		test_errors = 0;
		flips       = 0;
		auto_mode   = modes[t];
		prio        = prios[t];
		file_index  = indices[t];
		download    = 1'b1;
		@(negedge clk_sys);
		for (a = 25'd0; a <= end_addrs[t]; a = a + 25'd2)
			write_word(t, a, word_for(t, a));
		repeat (4) @(negedge clk_sys); // Let the region choice settle
		compare(names[t], "region_set", 32'(exp_set[t]), 32'(region_set));
		if (exp_set[t])
			compare(names[t], "region_req", 32'(exp_region[t]), 32'(region_req));
		download = 1'b0;
		repeat (6) @(negedge clk_sys);
		compare(names[t], "rom_size", 32'(end_addrs[t]), 32'(rom_size));
		compare(names[t], "rom_wr flips", 32'(int'(end_addrs[t] >> 1) + 1), 32'(flips));
		compare(names[t], "quirks", 32'(exp_quirks[t]), 32'(quirks));
		compare(names[t], "gun_type", 32'(exp_gun[t]), 32'(gun_type));
		compare(names[t], "gun_sensor_delay", 32'(exp_delay[t]), 32'(gun_sensor_delay));
		compare(names[t], "region_set after", 32'd0, 32'(region_set));
		$display("%s %s", (test_errors == 0) ? "PASS" : "FAIL", names[t]);
		if (test_errors != 0)
			failed_tests++;
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		RESET      = 1'b1;
		download   = 1'b0;
		wr         = 1'b0;
		addr       = '0;
		data       = '0;
		file_index = 8'h00;
		auto_mode  = DISABLED;
		prio       = US_EU_JP;

		// Name, code, region words, mode, priority, index, then expected values
		add_test("sram", "T-081276", 16'h554A, 16'h0000, HEADER, US_EU_JP, 8'h00,
			8'h80, 1'b0, 8'd44, US, 1'b1, 25'h200);
		add_test("eeprom", "MK-1215 ", 16'h554A, 16'h4500, HEADER, EU_US_JP, 8'h00,
			8'h40, 1'b0, 8'd44, US, 1'b1, 25'h204);
		add_test("noram", "T-113016", 16'h554A, 16'h4500, HEADER, US_JP_EU, 8'h00,
			8'h20, 1'b0, 8'd44, US, 1'b1, 25'h20E);
		add_test("fifo", "T-89016 ", 16'h554A, 16'h4500, HEADER, JP_US_EU, 8'h00,
			8'h10, 1'b0, 8'd44, JP, 1'b1, 25'h200);
		add_test("pier", "T-574023", 16'h2020, 16'h2045, HEADER, US_EU_JP, 8'h00,
			8'h08, 1'b0, 8'd44, EU, 1'b1, 25'h23E);
		add_test("svp", "MK-1229 ", 16'h2045, 16'h0000, HEADER, EU_US_JP, 8'h00,
			8'h04, 1'b0, 8'd44, EU, 1'b1, 25'h200);
		add_test("fmbusy", "T-35036 ", 16'h2045, 16'h0000, HEADER, US_JP_EU, 8'h00,
			8'h02, 1'b0, 8'd44, EU, 1'b1, 25'h2FE);
		add_test("schan", "T-68???-", 16'h2045, 16'h0000, HEADER, JP_US_EU, 8'h00,
			8'h01, 1'b0, 8'd44, EU, 1'b1, 25'h200);
		add_test("unknown_after_flag", "GM-00000", 16'h0000, 16'h0000, HEADER, US_EU_JP,
			8'h00, 8'h00, 1'b0, 8'd44, US, 1'b1, 25'h202);
		add_test("justifier", "T-95096-", 16'h0000, 16'h0000, HEADER, EU_US_JP, 8'h00,
			8'h00, 1'b1, 8'd52, EU, 1'b1, 25'h200);
		add_test("menacer", "MK-1533 ", 16'h0000, 16'h0000, HEADER, US_JP_EU, 8'h00,
			8'h00, 1'b0, 8'd100, US, 1'b1, 25'h200);
		add_test("unknown_after_gun", "UNKNOWN1", 16'h0000, 16'h0000, HEADER, JP_US_EU,
			8'h00, 8'h00, 1'b0, 8'd44, JP, 1'b1, 25'h200);
		add_test("file_ext_eu", "UNKNOWN2", 16'h554A, 16'h0000, FILE_EXT, US_EU_JP, 8'h81,
			8'h00, 1'b0, 8'd44, EU, 1'b1, 25'h200);
		add_test("file_ext_zero", "UNKNOWN2", 16'h554A, 16'h0000, FILE_EXT, US_EU_JP, 8'h00,
			8'h00, 1'b0, 8'd44, JP, 1'b0, 25'h200);
		add_test("disabled", "UNKNOWN3", 16'h554A, 16'h0000, DISABLED, US_EU_JP, 8'h40,
			8'h00, 1'b0, 8'd44, JP, 1'b0, 25'h200);

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
		compare("reset", "ioctl_wait", 32'd0, 32'(ioctl_wait));
		compare("reset", "region_set", 32'd0, 32'(region_set));
		compare("reset", "gun_sensor_delay", 32'(`GUN_DELAY_DEFAULT), 32'(gun_sensor_delay));

		for (int i = 0; i < num_tests; i++)
			run_test(i);

		$display("Tests run %0d, tests failed %0d, check errors %0d",
			num_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog allows 8 cycles per word of the longest image plus slack
	initial begin
		int max_words;
		#1;
		max_words = 0;
		for (int i = 0; i < num_tests; i++)
			if (int'(end_addrs[i] >> 1) + 1 > max_words)
				max_words = int'(end_addrs[i] >> 1) + 1;
		limit = num_tests * max_words * 8 + 100;
		repeat (limit) @(posedge clk_sys);
		$display("Watchdog expired, the downloads did not finish within %0d cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* list.f */
+incdir+logic
logic/cart_pkg.sv
logic/cart_dl_if.sv
logic/rom_write_tracker.sv
logic/cart_header_scan.sv
logic/quirk_table.sv
logic/region_select.sv
logic/cart_loader.sv
bench/cart_loader_tb.sv

/* run.sh */
#!/bin/sh
# Build the cartridge loader testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module cart_loader_tb -o cart_loader_sim
out=$(./obj_dir/cart_loader_sim)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
	exit 0
else
	exit 1
fi
